// ==== source/vic_sprites_pkg.sv ====
package vic_sprites_pkg;

   // sizes of the sprite block
   localparam int SHAPE_BITS          = 24;   // pixels per sprite line
   localparam int MAX_SPRITES         = 8;    // register map has room for eight
   localparam int DEFAULT_NUM_SPRITES = 8;
   localparam int DEFAULT_LINE_PIXELS = 504;  // raster period, pal style line

   typedef logic [3:0]                         color_t;     // palette index
   typedef logic [8:0]                         xpos_t;      // raster or sprite x
   typedef logic [SHAPE_BITS-1:0]              shape_t;     // one line of shape, msb first
   typedef logic [5:0]                         reg_addr_t;  // cpu register offset
   typedef logic [7:0]                         bus_data_t;  // cpu data byte
   typedef logic [$clog2(MAX_SPRITES)-1:0]     sprite_sel_t; // sprite index on shape load

   // register offsets, same places as on the real chip
   localparam reg_addr_t REG_X0         = 6'h00;  // x low byte of sprite n at $00 + 2n
   localparam reg_addr_t REG_XMSB       = 6'h10;  // x bit 8, one bit per sprite
   localparam reg_addr_t REG_ENABLE     = 6'h15;
   localparam reg_addr_t REG_IRQ_STATUS = 6'h19;  // write 1 to clear
   localparam reg_addr_t REG_IRQ_ENABLE = 6'h1A;
   localparam reg_addr_t REG_COLLIDE    = 6'h1E;  // sprite-sprite, clear on read
   localparam reg_addr_t REG_BACKGROUND = 6'h21;
   localparam reg_addr_t REG_COLOR0     = 6'h27;  // colour of sprite n at $27 + n

   localparam int        STATUS_COLLIDE_BIT = 2;      // sprite-sprite flag in status/enable
   localparam bus_data_t READ_FILL          = 8'hFF;  // unmapped offsets float high

endpackage : vic_sprites_pkg

// ==== source/sprite_cfg_if.sv ====
`timescale 1ns/1ps

// register file view handed to every sprite unit
interface sprite_cfg_if
   import vic_sprites_pkg::*;
#(
   parameter int NUM_SPRITES = DEFAULT_NUM_SPRITES
) ();

   xpos_t                  raster_x;                    // current raster pixel
   xpos_t                  sprite_x     [NUM_SPRITES];  // 9 bit start position
   logic [NUM_SPRITES-1:0] sprite_en;
   color_t                 sprite_color [NUM_SPRITES];
   color_t                 background;                  // only the mux uses this
   logic                   shape_load;                  // one cycle strobe
   sprite_sel_t            shape_sel;                   // which unit takes the shape
   shape_t                 shape_bits;

   modport regs (
      output raster_x, sprite_x, sprite_en, sprite_color, background,
      output shape_load, shape_sel, shape_bits
   );

   modport unit (
      input raster_x, sprite_x, sprite_en, sprite_color,
      input shape_load, shape_sel, shape_bits
   );

endinterface : sprite_cfg_if

// ==== source/sprite_pix_if.sv ====
`timescale 1ns/1ps

// per sprite pixel stream into the priority mux
interface sprite_pix_if
   import vic_sprites_pkg::*;
#(
   parameter int NUM_SPRITES = DEFAULT_NUM_SPRITES
) ();

   logic   opaque [NUM_SPRITES];  // each unit drives its own entry
   color_t color  [NUM_SPRITES];
   xpos_t  pix_x;                 // raster x of this pixel, from unit 0

   modport unit (
      output opaque, color, pix_x
   );

   modport mux (
      input opaque, color, pix_x
   );

endinterface : sprite_pix_if

// ==== source/sprite_regs.sv ====
`timescale 1ns/1ps

module sprite_regs
   import vic_sprites_pkg::*;
#(
   parameter int NUM_SPRITES = DEFAULT_NUM_SPRITES,
   parameter int LINE_PIXELS = DEFAULT_LINE_PIXELS
) (
   input  logic                   sys_clock,
   input  logic                   rst_n,
   input  logic                   ce,            // active low chip enable
   input  logic                   rw,            // 1 = read
   input  reg_addr_t              adi,
   input  bus_data_t              dbi,
   output bus_data_t              dbo,
   output logic                   irq,           // active low
   input  logic                   shape_load,
   input  sprite_sel_t            shape_sel,
   input  shape_t                 shape_bits,
   input  logic [NUM_SPRITES-1:0] collide_mask,  // opaque set from the mux
   input  logic                   collide_pulse,
   sprite_cfg_if.regs             cfg
);

   localparam xpos_t LAST_X = xpos_t'(LINE_PIXELS - 1);

   logic      wr_stb;
   logic      rd_stb;
   logic      collide_rd;
   bus_data_t collide_hits;
   bus_data_t x_lo      [NUM_SPRITES];
   color_t    spr_color [NUM_SPRITES];
   bus_data_t x_msb;
   bus_data_t spr_enable;
   bus_data_t irq_enable;
   color_t    bg_color;
   bus_data_t collide_q;     // sprite-sprite collision latch
   logic      collide_flag;  // irq status bit 2
   logic      irq_q;
   xpos_t     raster_q;
   bus_data_t rd_data;

   assign wr_stb       = !ce && !rw;
   assign rd_stb       = !ce && rw;
   assign collide_rd   = rd_stb && (adi == REG_COLLIDE);
   assign collide_hits = collide_pulse ? bus_data_t'(collide_mask) : '0;

   // cpu writes, new values reach the units next cycle
   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_SPRITES; i++) begin
            x_lo[i]      <= '0;
            spr_color[i] <= '0;
         end
         x_msb      <= '0;
         spr_enable <= '0;
         irq_enable <= '0;
         bg_color   <= '0;
      end else if (wr_stb) begin
         for (int i = 0; i < NUM_SPRITES; i++) begin
            if (adi == REG_X0 + reg_addr_t'(2 * i))
               x_lo[i] <= dbi;
            if (adi == REG_COLOR0 + reg_addr_t'(i))
               spr_color[i] <= dbi[3:0];  // upper nibble not stored
         end
         case (adi)
            REG_XMSB:       x_msb      <= dbi;
            REG_ENABLE:     spr_enable <= dbi;
            REG_IRQ_ENABLE: irq_enable <= dbi;
            REG_BACKGROUND: bg_color   <= dbi[3:0];
            default: ;
         endcase
      end
   end

   // collision latch and interrupt flag
   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         collide_q    <= '0;
         collide_flag <= 1'b0;
         irq_q        <= 1'b1;
      end else begin
         if (collide_rd)
            collide_q <= collide_hits;  // hits landing on the read edge are kept
         else
            collide_q <= collide_q | collide_hits;
         if (collide_pulse)
            collide_flag <= 1'b1;  // set beats a same-cycle clear
         else if (wr_stb && adi == REG_IRQ_STATUS && dbi[STATUS_COLLIDE_BIT])
            collide_flag <= 1'b0;
         irq_q <= !(collide_flag && irq_enable[STATUS_COLLIDE_BIT]);  // one cycle later
      end
   end

   // raster pixel counter
   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n)
         raster_q <= '0;
      else if (raster_q == LAST_X)
         raster_q <= '0;  // wrap at end of line
      else
         raster_q <= raster_q + 1'b1;
   end

   // read data select
   always_comb begin
      rd_data = READ_FILL;
      case (adi)
         REG_XMSB:       rd_data = x_msb;
         REG_ENABLE:     rd_data = spr_enable;
         REG_IRQ_STATUS: rd_data = bus_data_t'(collide_flag) << STATUS_COLLIDE_BIT;
         REG_IRQ_ENABLE: rd_data = irq_enable;
         REG_COLLIDE:    rd_data = collide_q;
         REG_BACKGROUND: rd_data = {4'h0, bg_color};
         default: ;
      endcase
      for (int i = 0; i < NUM_SPRITES; i++) begin
         if (adi == REG_X0 + reg_addr_t'(2 * i))
            rd_data = x_lo[i];
         if (adi == REG_COLOR0 + reg_addr_t'(i))
            rd_data = {4'h0, spr_color[i]};
      end
   end

   // dbo holds until the next read
   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n)
         dbo <= '0;
      else if (rd_stb)
         dbo <= rd_data;
   end

   assign irq = irq_q;

   for (genvar i = 0; i < NUM_SPRITES; i++) begin : g_cfg
      assign cfg.sprite_x[i]     = {x_msb[i], x_lo[i]};
      assign cfg.sprite_color[i] = spr_color[i];
   end

   assign cfg.raster_x   = raster_q;
   assign cfg.sprite_en  = spr_enable[NUM_SPRITES-1:0];
   assign cfg.background = bg_color;
   assign cfg.shape_load = shape_load;  // stands in for the shape fetch
   assign cfg.shape_sel  = shape_sel;
   assign cfg.shape_bits = shape_bits;

endmodule : sprite_regs

// ==== source/sprite_unit.sv ====
`timescale 1ns/1ps

module sprite_unit
   import vic_sprites_pkg::*;
#(
   parameter int INDEX = 0
) (
   input  logic       sys_clock,
   input  logic       rst_n,
   sprite_cfg_if.unit cfg,
   sprite_pix_if.unit pix
);

   localparam int CNT_W = $clog2(SHAPE_BITS + 1);

   logic             load_hit;
   logic             start;
   logic             shifting;
   logic             armed_q;   // shape loaded, waiting for x match
   logic [CNT_W-1:0] left_q;    // pixels still to shift after the first
   shape_t           shift_q;
   logic             opaque_q;
   color_t           color_q;

   assign load_hit = cfg.shape_load && (cfg.shape_sel == sprite_sel_t'(INDEX));
   assign start    = armed_q && cfg.sprite_en[INDEX]
                     && (cfg.raster_x == cfg.sprite_x[INDEX]);
   assign shifting = (left_q != '0);

   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         armed_q  <= 1'b0;
         left_q   <= '0;
         opaque_q <= 1'b0;
      end else if (load_hit) begin
         armed_q  <= 1'b1;  // reload restarts the line
         left_q   <= '0;
         opaque_q <= 1'b0;
      end else if (start) begin
         armed_q  <= 1'b0;
         left_q   <= CNT_W'(SHAPE_BITS - 1);
         opaque_q <= shift_q[SHAPE_BITS-1];  // bit 23 is the pixel at x
      end else if (shifting) begin
         left_q   <= left_q - 1'b1;
         opaque_q <= shift_q[SHAPE_BITS-1] && cfg.sprite_en[INDEX];  // masked if disabled
      end else begin
         opaque_q <= 1'b0;
      end
   end

   // shape shifter, msb out first
   always_ff @(posedge sys_clock) begin
      if (load_hit)
         shift_q <= cfg.shape_bits;
      else if (start || shifting)
         shift_q <= shift_q << 1;
   end

   always_ff @(posedge sys_clock) begin
      color_q <= cfg.sprite_color[INDEX];  // follows opaque_q by the same cycle
   end

   assign pix.opaque[INDEX] = opaque_q;
   assign pix.color[INDEX]  = color_q;

   // unit 0 also carries the raster x down the pipe
   if (INDEX == 0) begin : g_pix_x
      xpos_t x_q;

      always_ff @(posedge sys_clock or negedge rst_n) begin
         if (!rst_n)
            x_q <= '0;
         else
            x_q <= cfg.raster_x;
      end

      assign pix.pix_x = x_q;
   end

endmodule : sprite_unit

// ==== source/sprite_priority_mux.sv ====
`timescale 1ns/1ps

module sprite_priority_mux
   import vic_sprites_pkg::*;
#(
   parameter int NUM_SPRITES = DEFAULT_NUM_SPRITES
) (
   input  logic                   sys_clock,
   input  logic                   rst_n,
   input  color_t                 background,
   sprite_pix_if.mux              pix,
   output xpos_t                  pixel_x,
   output color_t                 pixel_color,
   output logic                   sprite_hit,    // some sprite is opaque here
   output logic [NUM_SPRITES-1:0] collide_mask,  // opaque set on a collision
   output logic                   collide_pulse
);

   logic [NUM_SPRITES-1:0] opaque_vec;
   color_t                 winner;
   logic                   multi_hit;

   // walk from the top so the lowest opaque index is the last to win
   always_comb begin
      winner = background;
      for (int i = NUM_SPRITES - 1; i >= 0; i--) begin
         opaque_vec[i] = pix.opaque[i];
         if (pix.opaque[i])
            winner = pix.color[i];
      end
   end

   // two or more bits set
   assign multi_hit = |(opaque_vec & (opaque_vec - 1'b1));

   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         pixel_x       <= '0;
         pixel_color   <= '0;
         sprite_hit    <= 1'b0;
         collide_mask  <= '0;
         collide_pulse <= 1'b0;
      end else begin
         pixel_x     <= pix.pix_x;  // x stays aligned with its pixel
         pixel_color <= winner;
         sprite_hit  <= |opaque_vec;
         if (multi_hit) begin
            collide_mask  <= opaque_vec;
            collide_pulse <= 1'b1;
         end else begin
            collide_mask  <= '0;  // a lone sprite is no collision
            collide_pulse <= 1'b0;
         end
      end
   end

endmodule : sprite_priority_mux

// ==== source/vic_sprites_top.sv ====
`timescale 1ns/1ps

module vic_sprites_top
   import vic_sprites_pkg::*;
#(
   parameter int NUM_SPRITES = DEFAULT_NUM_SPRITES,
   parameter int LINE_PIXELS = DEFAULT_LINE_PIXELS
) (
   input  logic        sys_clock,
   input  logic        rst_n,
   input  logic        ce,           // low = chip selected
   input  logic        rw,           // high = cpu read
   input  reg_addr_t   adi,
   input  bus_data_t   dbi,
   input  logic        shape_load,   // shape line strobe
   input  sprite_sel_t shape_sel,
   input  shape_t      shape_bits,
   output bus_data_t   dbo,
   output logic        irq,          // low while an enabled flag is set
   output xpos_t       pixel_x,
   output color_t      pixel_color,
   output logic        sprite_hit
);

   logic [NUM_SPRITES-1:0] collide_mask;
   logic                   collide_pulse;

   sprite_cfg_if #(.NUM_SPRITES(NUM_SPRITES)) cfg_bus ();
   sprite_pix_if #(.NUM_SPRITES(NUM_SPRITES)) pix_bus ();

   sprite_regs #(
      .NUM_SPRITES (NUM_SPRITES),
      .LINE_PIXELS (LINE_PIXELS)
   ) sprite_regs_i (
      .sys_clock     (sys_clock),
      .rst_n         (rst_n),
      .ce            (ce),
      .rw            (rw),
      .adi           (adi),
      .dbi           (dbi),
      .dbo           (dbo),
      .irq           (irq),
      .shape_load    (shape_load),
      .shape_sel     (shape_sel),
      .shape_bits    (shape_bits),
      .collide_mask  (collide_mask),
      .collide_pulse (collide_pulse),
      .cfg           (cfg_bus.regs)
   );

   // one unit per sprite, each owns its slot in pix_bus
   for (genvar i = 0; i < NUM_SPRITES; i++) begin : g_unit
      sprite_unit #(
         .INDEX (i)
      ) sprite_unit_i (
         .sys_clock (sys_clock),
         .rst_n     (rst_n),
         .cfg       (cfg_bus.unit),
         .pix       (pix_bus.unit)
      );
   end

   sprite_priority_mux #(
      .NUM_SPRITES (NUM_SPRITES)
   ) sprite_priority_mux_i (
      .sys_clock     (sys_clock),
      .rst_n         (rst_n),
      .background    (cfg_bus.background),  // straight from the register file
      .pix           (pix_bus.mux),
      .pixel_x       (pixel_x),
      .pixel_color   (pixel_color),
      .sprite_hit    (sprite_hit),
      .collide_mask  (collide_mask),
      .collide_pulse (collide_pulse)
   );

endmodule : vic_sprites_top

// ==== testbench/vic_sprites_tb.sv ====
`timescale 1ns/1ps

module vic_sprites_tb
   import vic_sprites_pkg::*;
();

   localparam int     NUM_SPRITES = 8;
   localparam int     LINE_PIXELS = 504;
   localparam int     CLK_PERIOD  = 100;
   localparam int     DRIVE_DELAY = 5;    // inputs move this long after the edge
   localparam int     NUM_LINES   = 40;
   localparam longint TIMEOUT_NS  = longint'(NUM_LINES + 6) * LINE_PIXELS * CLK_PERIOD;

   logic        sys_clock;
   logic        rst_n;
   logic        ce;
   logic        rw;
   reg_addr_t   adi;
   bus_data_t   dbi;
   logic        shape_load;
   sprite_sel_t shape_sel;
   shape_t      shape_bits;
   bus_data_t   dbo;
   logic        irq;
   xpos_t       pixel_x;
   color_t      pixel_color;
   logic        sprite_hit;

   logic [31:0] lfsr = 32'h6dd5c065;
   int          collide_reads;   // collide reads that came back non-zero
   int          irq_low_cycles;

   // reference model state
   bus_data_t m_x_lo  [NUM_SPRITES];
   color_t    m_color [NUM_SPRITES];
   bus_data_t m_xmsb, m_enable, m_irq_en, m_collide, m_dbo;
   bus_data_t m_cmask;                 // collision set leaving the merge stage
   color_t    m_bg, m_pcol;
   logic      m_flag, m_irq, m_hit;
   xpos_t     m_raster, m_px, s1_x;
   shape_t    m_shape [NUM_SPRITES];
   logic      m_armed [NUM_SPRITES];
   int        m_pos   [NUM_SPRITES];   // next shape pixel, SHAPE_BITS when idle
   logic      s1_opq  [NUM_SPRITES];   // unit outputs, one cycle behind raster
   color_t    s1_col  [NUM_SPRITES];

   vic_sprites_top #(
      .NUM_SPRITES (NUM_SPRITES),
      .LINE_PIXELS (LINE_PIXELS)
   ) vic_sprites_top_i (
      .sys_clock, .rst_n, .ce, .rw, .adi, .dbi, .shape_load, .shape_sel, .shape_bits,
      .dbo, .irq, .pixel_x, .pixel_color, .sprite_hit
   );

   initial begin
      sys_clock = 1'b0;
      forever #(CLK_PERIOD / 2) sys_clock = ~sys_clock;
   end

   initial begin
      #(TIMEOUT_NS);
      report_fail("run timed out before all lines were checked");
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
   endfunction

   // one lfsr step per returned bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsr_next(lfsr);
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at first failure");
   endtask

   task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
      if (got !== exp)
         report_fail($sformatf("Error: %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_pixel(input xpos_t got_x, input xpos_t exp_x, input color_t got_c,
                              input color_t exp_c, input logic got_hit, input logic exp_hit);
      if (got_x !== exp_x)
         report_fail($sformatf("Error: pixel_x got %h expected %h", got_x, exp_x));
      if (got_c !== exp_c)
         report_fail($sformatf("Error: pixel_color got %h expected %h at pixel_x %h",
                               got_c, exp_c, got_x));
      if (got_hit !== exp_hit)
         report_fail($sformatf("Error: sprite_hit got %h expected %h at pixel_x %h",
                               got_hit, exp_hit, got_x));
   endtask

   task automatic check_irq(input logic got, input logic exp);
      if (got !== exp)
         report_fail($sformatf("Error: irq got %h expected %h", got, exp));
   endtask

   // register map as the cpu sees it
   function automatic bus_data_t model_read(input reg_addr_t a);
      int i;
      i = int'(a);
      if (i < 2 * NUM_SPRITES)
         return i[0] ? 8'hFF : m_x_lo[i / 2];  // odd offsets in the x block are holes
      if (i >= int'(REG_COLOR0) && i < int'(REG_COLOR0) + NUM_SPRITES)
         return {4'h0, m_color[i - int'(REG_COLOR0)]};
      case (a)
         REG_XMSB:       return m_xmsb;
         REG_ENABLE:     return m_enable;
         REG_IRQ_STATUS: return {5'b0, m_flag, 2'b0};
         REG_IRQ_ENABLE: return m_irq_en;
         REG_COLLIDE:    return m_collide;
         REG_BACKGROUND: return {4'h0, m_bg};
         default:        return 8'hFF;
      endcase
   endfunction

   task automatic model_reset();
      for (int i = 0; i < NUM_SPRITES; i++) begin
         m_x_lo[i]  = '0;
         m_color[i] = '0;
         m_armed[i] = 1'b0;
         m_pos[i]   = SHAPE_BITS;
         s1_opq[i]  = 1'b0;
         s1_col[i]  = '0;
      end
      {m_xmsb, m_enable, m_irq_en, m_collide, m_dbo, m_cmask} = '0;
      {m_bg, m_pcol, m_flag, m_hit, m_raster, m_px, s1_x} = '0;
      m_irq = 1'b1;
   endtask

   // one clock edge of the model, every term uses pre-edge values
   task automatic model_step();
      logic      wr;
      logic      rd;
      bus_data_t opq_set;
      color_t    win;
      int        n_opq;
      xpos_t     sx;
      if (!rst_n) begin
         model_reset();
         return;
      end
      wr      = !ce && !rw;
      rd      = !ce && rw;
      opq_set = '0;
      n_opq   = 0;
      win     = m_bg;
      for (int i = 0; i < NUM_SPRITES; i++) begin
         if (s1_opq[i]) begin
            if (n_opq == 0)
               win = s1_col[i];  // first opaque sprite has priority
            n_opq++;
            opq_set[i] = 1'b1;
         end
      end
      if (rd)
         m_dbo = model_read(adi);
      m_irq = !(m_flag && m_irq_en[2]);  // lags the flag by one edge
      if (rd && adi == REG_COLLIDE)
         m_collide = m_cmask;  // hits on the read edge survive the clear
      else
         m_collide |= m_cmask;
      if (m_cmask != '0)
         m_flag = 1'b1;
      else if (wr && adi == REG_IRQ_STATUS && dbi[2])
         m_flag = 1'b0;
      for (int i = 0; i < NUM_SPRITES; i++) begin
         sx        = {m_xmsb[i], m_x_lo[i]};
         s1_col[i] = m_color[i];
         if (shape_load && shape_sel == i) begin
            m_shape[i] = shape_bits;
            m_armed[i] = 1'b1;
            m_pos[i]   = SHAPE_BITS;
            s1_opq[i]  = 1'b0;
         end else if (m_armed[i] && m_enable[i] && m_raster == sx) begin
            m_armed[i] = 1'b0;
            s1_opq[i]  = m_shape[i][SHAPE_BITS-1];
            m_pos[i]   = 1;
         end else if (m_pos[i] < SHAPE_BITS) begin
            s1_opq[i] = m_shape[i][SHAPE_BITS-1-m_pos[i]] && m_enable[i];
            m_pos[i]++;
         end else begin
            s1_opq[i] = 1'b0;
         end
      end
      m_px     = s1_x;
      m_pcol   = win;
      m_hit    = (n_opq != 0);
      m_cmask  = (n_opq >= 2) ? opq_set : '0;
      s1_x     = m_raster;
      m_raster = (m_raster == LINE_PIXELS - 1) ? '0 : m_raster + 1'b1;
      if (wr) begin
         for (int i = 0; i < NUM_SPRITES; i++) begin
            if (adi == reg_addr_t'(2 * i))
               m_x_lo[i] = dbi;
            if (adi == REG_COLOR0 + reg_addr_t'(i))
               m_color[i] = dbi[3:0];
         end
         case (adi)
            REG_XMSB:       m_xmsb   = dbi;
            REG_ENABLE:     m_enable = dbi;
            REG_IRQ_ENABLE: m_irq_en = dbi;
            REG_BACKGROUND: m_bg     = dbi[3:0];
            default: ;
         endcase
      end
   endtask

   // advance one clock and compare every output
   task automatic tick();
      @(posedge sys_clock);
      model_step();
      #(DRIVE_DELAY);
      check_pixel(pixel_x, m_px, pixel_color, m_pcol, sprite_hit, m_hit);
      check_data("dbo", dbo, m_dbo);
      check_irq(irq, m_irq);
      if (!irq)
         irq_low_cycles++;
   endtask

   task automatic bus_write(input reg_addr_t a, input bus_data_t d);
      ce  = 1'b0;
      rw  = 1'b0;
      adi = a;
      dbi = d;
      tick();
      ce  = 1'b1;
      rw  = 1'b1;
   endtask

   task automatic bus_read(input reg_addr_t a, output bus_data_t d);
      ce  = 1'b0;
      rw  = 1'b1;
      adi = a;
      tick();
      ce  = 1'b1;
      d   = dbo;  // valid from the edge after the access
   endtask

   task automatic write_readback(input reg_addr_t a, input bus_data_t d, input bus_data_t exp);
      bus_data_t got;
      bus_write(a, d);
      bus_read(a, got);
      check_data($sformatf("dbo at offset %h", a), got, exp);
   endtask

   task automatic register_test();
      bus_data_t d;
      for (int i = 0; i < NUM_SPRITES; i++) begin
         d = bus_data_t'(rand_bits(8));
         write_readback(REG_X0 + reg_addr_t'(2 * i), d, d);
         d = bus_data_t'(rand_bits(8));
         write_readback(REG_COLOR0 + reg_addr_t'(i), d, {4'h0, d[3:0]});  // 4 bit colour
      end
      d = bus_data_t'(rand_bits(8));
      write_readback(REG_XMSB, d, d);
      d = bus_data_t'(rand_bits(8));
      write_readback(REG_ENABLE, d, d);
      d = bus_data_t'(rand_bits(8));
      write_readback(REG_IRQ_ENABLE, d, d);
      d = bus_data_t'(rand_bits(8));
      write_readback(REG_BACKGROUND, d, {4'h0, d[3:0]});
      write_readback(REG_COLLIDE, 8'hFF, 8'h00);  // nothing loaded yet so nothing collided
      write_readback(REG_IRQ_STATUS, 8'hFF, 8'h00);
      write_readback(6'h01, 8'h5A, 8'hFF);
      write_readback(6'h11, 8'hA5, 8'hFF);
      write_readback(6'h3F, 8'h00, 8'hFF);
   endtask

   task automatic run_line(input int line);
      bus_data_t d;
      bus_data_t msb;
      xpos_t     base;
      xpos_t     x;
      while (m_raster != 0)
         tick();
      if (line < 4 || line % 4 == 0) begin
         base = xpos_t'(100 + rand_bits(8));  // bunch sprites up so they overlap
         msb  = '0;
         for (int i = 0; i < NUM_SPRITES; i++) begin
            x      = base + xpos_t'(rand_bits(5));
            msb[i] = x[8];
            bus_write(REG_X0 + reg_addr_t'(2 * i), x[7:0]);
            bus_write(REG_COLOR0 + reg_addr_t'(i), bus_data_t'(rand_bits(8)));
         end
         bus_write(REG_XMSB, msb);
         d = (line < 4) ? 8'h01 << rand_bits(3) : bus_data_t'(rand_bits(8));  // lone sprite first
         bus_write(REG_ENABLE, d);
         bus_write(REG_BACKGROUND, bus_data_t'(rand_bits(8)));
         d    = bus_data_t'(rand_bits(8));
         d[2] = (line % 8 == 4);  // collision irq on every other reconfig
         bus_write(REG_IRQ_ENABLE, d);
      end
      for (int i = 0; i < NUM_SPRITES; i++) begin
         if (line < 4 || rand_bits(1)) begin
            shape_load = 1'b1;
            shape_sel  = sprite_sel_t'(i);
            shape_bits = shape_t'(rand_bits(SHAPE_BITS));
            tick();
            shape_load = 1'b0;
         end
      end
      while (m_raster != LINE_PIXELS - 20)
         tick();
      bus_read(REG_COLLIDE, d);
      if (d != '0)
         collide_reads++;
      bus_read(REG_COLLIDE, d);
      check_data("dbo on second collide read", d, 8'h00);
      bus_read(REG_IRQ_STATUS, d);
      if (d[2] && rand_bits(1))
         bus_write(REG_IRQ_STATUS, 8'h04);  // write 1 releases irq
   endtask

   initial begin
      rst_n          = 1'b0;
      ce             = 1'b1;
      rw             = 1'b1;
      adi            = '0;
      dbi            = '0;
      shape_load     = 1'b0;
      shape_sel      = '0;
      shape_bits     = '0;
      collide_reads  = 0;
      irq_low_cycles = 0;
      model_reset();
      repeat (4) tick();
      rst_n = 1'b1;
      register_test();
      for (int line = 0; line < NUM_LINES; line++)
         run_line(line);
      if (collide_reads == 0 || irq_low_cycles == 0) begin
         report_fail("the random lines never produced a collision interrupt");
      end else begin
         $display("TEST RESULT: PASS");
         $finish;
      end
   end

endmodule : vic_sprites_tb

// ==== vic_sprites.f ====
source/vic_sprites_pkg.sv
source/sprite_cfg_if.sv
source/sprite_pix_if.sv
source/sprite_regs.sv
source/sprite_unit.sv
source/sprite_priority_mux.sv
source/vic_sprites_top.sv
testbench/vic_sprites_tb.sv

// ==== Bender.yml ====
package:
  name: vic_sprites

sources:
  - source/vic_sprites_pkg.sv
  - source/sprite_cfg_if.sv
  - source/sprite_pix_if.sv
  - source/sprite_regs.sv
  - source/sprite_unit.sv
  - source/sprite_priority_mux.sv
  - source/vic_sprites_top.sv
  - target: test
    files:
      - testbench/vic_sprites_tb.sv
